// ==== Bender.yml ====
package:
  name: color_convert

sources:
  # packages first
  - hdl/pixelPkg.sv
  - hdl/colorCoefPkg.sv
  # RTL
  - hdl/pixelIngress.sv
  - hdl/dotProductLane.sv
  - hdl/pixelEgress.sv
  - hdl/colorConvert.sv
  # testbench
  - target: test
    files:
      - verif/colorConvertTb.sv

// ==== files.f ====
hdl/pixelPkg.sv
hdl/colorCoefPkg.sv
hdl/pixelIngress.sv
hdl/dotProductLane.sv
hdl/pixelEgress.sv
hdl/colorConvert.sv
verif/colorConvertTb.sv

// ==== hdl/colorCoefPkg.sv ====
package colorCoefPkg;

	// output channels, one lane each
	localparam int channelCount = 3;

	// coefficients are signed with 14 fraction bits
	localparam int fracBits = 14;
	localparam int coefWidth = 16;

	// BT.601 rows, columns ordered r, g, b
	localparam logic signed [coefWidth-1:0] coefMatrix [channelCount][channelCount] = '{
		'{ 4899,  9617,  1868},
		'{-2765, -5427,  8192},
		'{ 8192, -6860, -1332}
	};

	// added after the shift, chroma is centred on 128
	localparam int channelOffset [channelCount] = '{0, 128, 128};

	// product of a zero-extended 8-bit channel and one coefficient
	localparam int productWidth = coefWidth + 8 + 1;
	// three products plus rounding, with headroom
	localparam int sumWidth = productWidth + 2;
	// integer part left after the shift
	localparam int resultWidth = sumWidth - fracBits;

	// half an lsb of the result, rounds half up
	localparam logic signed [sumWidth-1:0] roundConst = 1 << (fracBits - 1);

	// products, sum, clamp
	localparam int laneLatency = 3;

endpackage

// ==== hdl/colorConvert.sv ====
`timescale 1ns/1ps

module colorConvert (
	input  logic               clk,
	input  logic               reset,
	input  logic               newFrame,
	input  logic               inValid,
	input  pixelPkg::pixelWord inPixel,
	input  logic               outCreditReturn,
	output logic               inCreditReturn,
	output logic               outValid,
	output pixelPkg::pixelWord outPixel,
	output logic               outLineEnd,
	output logic               outFrameEnd
);

	logic chanValid;
	logic [pixelPkg::channelWidth-1:0] chanR;
	logic [pixelPkg::channelWidth-1:0] chanG;
	logic [pixelPkg::channelWidth-1:0] chanB;
	logic lineEnd;
	logic frameEnd;
	logic [colorCoefPkg::channelCount-1:0] laneValid;
	logic [colorCoefPkg::channelCount-1:0][pixelPkg::channelWidth-1:0] laneResult;

	pixelIngress ingress (
		.clk(clk), .reset(reset), .newFrame(newFrame), .inValid(inValid), .inPixel(inPixel),
		.chanValid(chanValid), .chanR(chanR), .chanG(chanG), .chanB(chanB),
		.lineEnd(lineEnd), .frameEnd(frameEnd)
	);

	// lane i computes y, cb, cr for i = 0, 1, 2
	for (genvar i = 0; i < colorCoefPkg::channelCount; i++) begin : gLane
		dotProductLane #(.row(i)) lane (
			.clk(clk), .reset(reset), .chanValid(chanValid),
			.chanR(chanR), .chanG(chanG), .chanB(chanB),
			.laneValid(laneValid[i]), .laneResult(laneResult[i])
		);
	end

	pixelEgress egress (
		.clk(clk), .reset(reset), .chanValid(chanValid), .lineEnd(lineEnd), .frameEnd(frameEnd),
		.laneValid(laneValid), .laneResult(laneResult), .outCreditReturn(outCreditReturn),
		.outValid(outValid), .outPixel(outPixel), .outLineEnd(outLineEnd),
		.outFrameEnd(outFrameEnd), .inCreditReturn(inCreditReturn)
	);

endmodule

// ==== hdl/dotProductLane.sv ====
`timescale 1ns/1ps

module dotProductLane #(
	parameter int row = 0
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                chanValid,
	input  logic [pixelPkg::channelWidth-1:0]   chanR,
	input  logic [pixelPkg::channelWidth-1:0]   chanG,
	input  logic [pixelPkg::channelWidth-1:0]   chanB,
	output logic                                laneValid,
	output logic [pixelPkg::channelWidth-1:0]   laneResult
);

	// signed products of stage one
	logic signed [colorCoefPkg::productWidth-1:0] prodR;
	logic signed [colorCoefPkg::productWidth-1:0] prodG;
	logic signed [colorCoefPkg::productWidth-1:0] prodB;

	// rounded sum of stage two
	logic signed [colorCoefPkg::sumWidth-1:0] sumReg;

	// stage three inputs
	logic signed [colorCoefPkg::resultWidth-1:0] shifted;
	logic signed [colorCoefPkg::resultWidth-1:0] offsetSum;
	logic signed [colorCoefPkg::resultWidth-1:0] clamped;

	// one valid bit per stage
	logic [colorCoefPkg::laneLatency-1:0] validPipe;

	always_ff @(posedge clk) begin
		if (reset) begin
			validPipe <= '0;
		end else begin
			validPipe <= {validPipe[colorCoefPkg::laneLatency-2:0], chanValid};
		end
	end

	assign laneValid = validPipe[colorCoefPkg::laneLatency-1];

	// arithmetic shift keeps the sign before offset and clamp
	always_comb begin
		shifted = colorCoefPkg::resultWidth'(sumReg >>> colorCoefPkg::fracBits);
		offsetSum = shifted + colorCoefPkg::resultWidth'(colorCoefPkg::channelOffset[row]);
		if (offsetSum < 0) begin
			clamped = '0;
		end else if (offsetSum > pixelPkg::channelMax) begin
			clamped = colorCoefPkg::resultWidth'(pixelPkg::channelMax);
		end else begin
			clamped = offsetSum;
		end
	end

	// free-running datapath where every stage moves each cycle
	always_ff @(posedge clk) begin
		// zero-extend the unsigned channels before the signed multiply
		prodR <= $signed({1'b0, chanR}) * colorCoefPkg::coefMatrix[row][0];
		prodG <= $signed({1'b0, chanG}) * colorCoefPkg::coefMatrix[row][1];
		prodB <= $signed({1'b0, chanB}) * colorCoefPkg::coefMatrix[row][2];
		sumReg <= prodR + prodG + prodB + colorCoefPkg::roundConst;
		laneResult <= clamped[pixelPkg::channelWidth-1:0];
	end

	// narrowing after the shift keeps every integer bit of the sum
	assert property (@(posedge clk) disable iff (reset)
		validPipe[colorCoefPkg::laneLatency-2] |->
			((sumReg >>> colorCoefPkg::fracBits) == shifted))
		else $error("lane %0d sum does not fit the result width", row);

endmodule

// ==== hdl/pixelEgress.sv ====
`timescale 1ns/1ps

module pixelEgress (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                chanValid,
	input  logic                                lineEnd,
	input  logic                                frameEnd,
	input  logic [colorCoefPkg::channelCount-1:0] laneValid,
	input  logic [colorCoefPkg::channelCount-1:0][pixelPkg::channelWidth-1:0] laneResult,
	input  logic                                outCreditReturn,
	output logic                                outValid,
	output pixelPkg::pixelWord                  outPixel,
	output logic                                outLineEnd,
	output logic                                outFrameEnd,
	output logic                                inCreditReturn
);

	// markers delayed to meet the lane results
	logic [colorCoefPkg::laneLatency-1:0] lineEndPipe;
	logic [colorCoefPkg::laneLatency-1:0] frameEndPipe;

	// FIFO storage with pixel and markers side by side
	pixelPkg::pixelWord fifoPixel [pixelPkg::bufferDepth];
	logic fifoLineEnd [pixelPkg::bufferDepth];
	logic fifoFrameEnd [pixelPkg::bufferDepth];
	logic [pixelPkg::fifoAddrWidth-1:0] wrPtr;
	logic [pixelPkg::fifoAddrWidth-1:0] rdPtr;
	logic [pixelPkg::fifoAddrWidth:0] count;

	logic [pixelPkg::creditWidth-1:0] credits;
	pixelPkg::pixelWord pushWord;
	logic push;
	logic pop;

	// lanes run in lockstep so any bit will do
	assign push = laneValid[0];
	assign pop = (count != 0) && (credits != 0);

	// write the ycc view from the three lanes
	always_comb begin
		pushWord.ycc.y = laneResult[0];
		pushWord.ycc.cb = laneResult[1];
		pushWord.ycc.cr = laneResult[2];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lineEndPipe <= '0;
			frameEndPipe <= '0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			credits <= pixelPkg::creditWidth'(pixelPkg::sinkCredits);
			outValid <= 1'b0;
			outLineEnd <= 1'b0;
			outFrameEnd <= 1'b0;
			inCreditReturn <= 1'b0;
		end else begin
			lineEndPipe <= {lineEndPipe[colorCoefPkg::laneLatency-2:0], chanValid & lineEnd};
			frameEndPipe <= {frameEndPipe[colorCoefPkg::laneLatency-2:0], chanValid & frameEnd};
			// pointers wrap by themselves on a power-of-two depth
			if (push) wrPtr <= wrPtr + 1'b1;
			if (pop) rdPtr <= rdPtr + 1'b1;
			count <= count + push - pop;
			credits <= credits + outCreditReturn - pop;
			outValid <= pop;
			outLineEnd <= pop && fifoLineEnd[rdPtr];
			outFrameEnd <= pop && fifoFrameEnd[rdPtr];
			// a pixel leaving frees a slot upstream
			inCreditReturn <= pop;
		end
	end

	// FIFO payload and output pixel
	always_ff @(posedge clk) begin
		if (push) begin
			fifoPixel[wrPtr] <= pushWord;
			fifoLineEnd[wrPtr] <= lineEndPipe[colorCoefPkg::laneLatency-1];
			fifoFrameEnd[wrPtr] <= frameEndPipe[colorCoefPkg::laneLatency-1];
		end
		if (pop) outPixel <= fifoPixel[rdPtr];
	end

	assert property (@(posedge clk) disable iff (reset) (laneValid == '0) || (laneValid == '1))
		else $error("lane valids out of step");
	// source credits keep the FIFO from overflowing
	assert property (@(posedge clk) disable iff (reset) push |-> (count != pixelPkg::bufferDepth))
		else $error("push into a full FIFO");
	assert property (@(posedge clk) disable iff (reset) credits <= pixelPkg::sinkCredits)
		else $error("sink returned more credits than granted");

endmodule

// ==== hdl/pixelIngress.sv ====
`timescale 1ns/1ps

module pixelIngress (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                newFrame,
	input  logic                                inValid,
	input  pixelPkg::pixelWord                  inPixel,
	output logic                                chanValid,
	output logic [pixelPkg::channelWidth-1:0]   chanR,
	output logic [pixelPkg::channelWidth-1:0]   chanG,
	output logic [pixelPkg::channelWidth-1:0]   chanB,
	output logic                                lineEnd,
	output logic                                frameEnd
);

	// position of the next pixel in the frame
	logic [pixelPkg::colWidth-1:0] col;
	logic [pixelPkg::rowWidth-1:0] row;
	logic lastCol;
	logic lastRow;

	assign lastCol = (col == pixelPkg::frameWidth - 1);
	assign lastRow = (row == pixelPkg::frameHeight - 1);

	// control path
	always_ff @(posedge clk) begin
		if (reset) begin
			chanValid <= 1'b0;
			lineEnd <= 1'b0;
			frameEnd <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			chanValid <= inValid;
			// tags belong to the pixel registered this cycle
			lineEnd <= inValid && lastCol;
			frameEnd <= inValid && lastCol && lastRow;
			if (newFrame) begin
				col <= '0;
				row <= '0;
			end else if (inValid) begin
				if (lastCol) begin
					col <= '0;
					// wrap rows too, in case no newFrame comes
					row <= lastRow ? '0 : row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// split the rgb view, payload holds when idle
	always_ff @(posedge clk) begin
		if (inValid) begin
			chanR <= inPixel.rgb.r;
			chanG <= inPixel.rgb.g;
			chanB <= inPixel.rgb.b;
		end
	end

	// newFrame goes out in a gap between pixels
	assert property (@(posedge clk) disable iff (reset) !(inValid && newFrame))
		else $error("newFrame coincides with a valid pixel");

endmodule

// ==== hdl/pixelPkg.sv ====
package pixelPkg;

	// one colour channel
	localparam int channelWidth = 8;
	localparam int channelMax = (1 << channelWidth) - 1;

	// frame geometry in pixels and lines
	localparam int frameWidth = 8;
	localparam int frameHeight = 4;
	localparam int colWidth = $clog2(frameWidth);
	localparam int rowWidth = $clog2(frameHeight);

	// source credits and egress FIFO depth are the same number
	localparam int bufferDepth = 8;
	localparam int fifoAddrWidth = $clog2(bufferDepth);

	// credits granted by the sink after reset
	localparam int sinkCredits = 4;
	localparam int creditWidth = $clog2(sinkCredits + 1);

	// input view, r in the top byte
	typedef struct packed {
		logic [channelWidth-1:0] r;
		logic [channelWidth-1:0] g;
		logic [channelWidth-1:0] b;
	} rgbView;

	// output view, y in the top byte
	typedef struct packed {
		logic [channelWidth-1:0] y;
		logic [channelWidth-1:0] cb;
		logic [channelWidth-1:0] cr;
	} yccView;

	// same 24 bits, read as rgb going in and ycc going out
	typedef union packed {
		rgbView rgb;
		yccView ycc;
	} pixelWord;

endpackage

// ==== verif/colorConvertTb.sv ====
`timescale 1ns/1ps

module colorConvertTb;

	// two full frames of pixels
	localparam int frameSize = pixelPkg::frameWidth * pixelPkg::frameHeight;
	localparam int tableLength = 2 * frameSize;
	localparam int fixedCount = 12;
	localparam int watchdogCycles = tableLength * 20 + 200;

	// {r, g, b, y, cb, cr}, expected values worked out by hand
	localparam logic [47:0] fixedEntries [fixedCount] = '{
		48'h000000_008080,
		48'hFFFFFF_FF8080,
		48'hFF0000_4C55FF,
		48'h00FF00_962C15,
		48'h0000FF_1DFF6B,
		48'hFFFF00_E20195,
		48'h00FFFF_B3AB01,
		48'hFF00FF_69D4EB,
		48'h808080_808080,
		48'h010101_018080,
		48'hFE00FF_69D5EA,
		48'h00FF01_962C15
	};

	logic clk;
	logic reset;
	logic newFrame;
	logic inValid;
	pixelPkg::pixelWord inPixel;
	logic outCreditReturn;
	logic inCreditReturn;
	logic outValid;
	pixelPkg::pixelWord outPixel;
	logic outLineEnd;
	logic outFrameEnd;

	logic [23:0] stimTable [tableLength];
	logic [23:0] expTable [tableLength];
	logic [23:0] expQueue [$];
	// cycle numbers at which the sink hands a credit back
	int dueQueue [$];
	int seed = 61833;
	int cycle = 0;
	int sentCount = 0;
	int returnCount = 0;
	int outCount = 0;
	int creditsGiven = 0;

	colorConvert UUT (
		.clk(clk), .reset(reset), .newFrame(newFrame), .inValid(inValid), .inPixel(inPixel),
		.outCreditReturn(outCreditReturn), .inCreditReturn(inCreditReturn),
		.outValid(outValid), .outPixel(outPixel), .outLineEnd(outLineEnd),
		.outFrameEnd(outFrameEnd)
	);

	// matrix, round half up, offset, clamp
	function automatic logic [23:0] rgbToYcc(input logic [23:0] rgb);
		int chan [3];
		int sum;
		logic [23:0] ycc;
		chan[0] = rgb[23:16];
		chan[1] = rgb[15:8];
		chan[2] = rgb[7:0];
		for (int k = 0; k < 3; k++) begin
			sum = 0;
			for (int j = 0; j < 3; j++) begin
				sum += chan[j] * int'(colorCoefPkg::coefMatrix[k][j]);
			end
			sum = (sum + (1 << (colorCoefPkg::fracBits - 1))) >>> colorCoefPkg::fracBits;
			sum += colorCoefPkg::channelOffset[k];
			if (sum < 0) begin
				sum = 0;
			end else if (sum > 255) begin
				sum = 255;
			end
			ycc[23 - 8 * k -: 8] = sum[7:0];
		end
		return ycc;
	endfunction

	task automatic compareValues(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Something failed");
			$fatal(1, "mismatch");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// nothing may run longer than this
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("timeout: only %0d of %0d pixels came out", outCount, tableLength);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

	// sink credit returns, one pulse per cycle at most
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (dueQueue.size() > 0 && cycle >= dueQueue[0]) begin
				outCreditReturn = 1'b1;
				void'(dueQueue.pop_front());
			end else begin
				outCreditReturn = 1'b0;
			end
		end
	end

	// output monitor, sampled mid-cycle
	initial begin
		int pos;
		int delay;
		forever begin
			@(negedge clk);
			if (!reset) begin
				compareValues(inCreditReturn, outValid, "source credit not paired with output");
				if (inCreditReturn) returnCount++;
				if (outValid) begin
					if (expQueue.size() == 0) begin
						$display("an output pixel appeared with no input outstanding");
						$display("Something failed");
						$fatal(1, "extra output");
					end else begin
						// sink may never be overrun
						compareValues(outCount + 1 <= pixelPkg::sinkCredits + creditsGiven, 1,
							"outputs exceed sink credits");
						compareValues(outPixel, expQueue.pop_front(),
							$sformatf("pixel %0d", outCount));
						pos = outCount % frameSize;
						compareValues(outLineEnd, pos % pixelPkg::frameWidth ==
							pixelPkg::frameWidth - 1, $sformatf("line end %0d", outCount));
						compareValues(outFrameEnd, pos == frameSize - 1,
							$sformatf("frame end %0d", outCount));
						delay = $unsigned($random(seed)) % 7;
						// hold credits back for a stretch so the FIFO fills
						if (outCount >= 20 && outCount < 28) delay += 40;
						dueQueue.push_back(cycle + 1 + delay);
						outCount++;
					end
				end
				if (outCreditReturn) creditsGiven++;
			end
		end
	end

	// reset, build the table, then act as the source
	initial begin
		newFrame = 1'b0;
		inValid = 1'b0;
		inPixel = '0;
		outCreditReturn = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < tableLength; i++) begin
			if (i < fixedCount) begin
				stimTable[i] = fixedEntries[i][47:24];
				expTable[i] = fixedEntries[i][23:0];
				// cross-check hand values against the reference
				compareValues(rgbToYcc(stimTable[i]), expTable[i], $sformatf("table %0d", i));
			end else begin
				stimTable[i] = 24'($random(seed));
				expTable[i] = rgbToYcc(stimTable[i]);
			end
		end
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < tableLength; i++) begin
			// frame start pulse in a gap
			if (i % frameSize == 0) begin
				inValid = 1'b0;
				newFrame = 1'b1;
				@(posedge clk);
				#1;
				newFrame = 1'b0;
			end
			while (sentCount - returnCount >= pixelPkg::bufferDepth) begin
				inValid = 1'b0;
				@(posedge clk);
				#1;
			end
			inValid = 1'b1;
			inPixel = stimTable[i];
			expQueue.push_back(expTable[i]);
			sentCount++;
			@(posedge clk);
			#1;
		end
		inValid = 1'b0;
		wait (outCount == tableLength);
		// room for a stray output to show up
		repeat (20) @(posedge clk);
		compareValues(returnCount, outCount, "source credits versus outputs");
		compareValues(expQueue.size(), 0, "pixels left over");
		$display("Everything OK");
		$finish;
	end

endmodule
